/* verilog/datapath_pkg.sv */
`default_nettype none

package datapath_pkg;

	// Data and address widths
	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] reg_onehot_t;
	typedef logic [8:0]  mem_addr_t;

	localparam int REG_COUNT = 16;

	// Instruction field positions
	localparam int IR_RA_MSB  = 26;
	localparam int IR_RB_MSB  = 22;
	localparam int IR_RC_MSB  = 18;
	localparam int IR_C_WIDTH = 19;
	localparam int IR_C2_LSB  = 19;

	// ALU operations, unlisted codes give zero
	typedef enum logic [4:0] {
		ALU_ADD = 5'b00011,
		ALU_SUB = 5'b00100,
		ALU_SHR = 5'b00101,
		ALU_SHL = 5'b00111,
		ALU_AND = 5'b01010,
		ALU_OR  = 5'b01011,
		ALU_MUL = 5'b01111,
		ALU_NEG = 5'b10001,
		ALU_NOT = 5'b10010
	} alu_op_t;

	// Branch condition held in C2
	typedef enum logic [1:0] {
		BR_ZERO     = 2'b00,
		BR_NONZERO  = 2'b01,
		BR_POSITIVE = 2'b10,
		BR_NEGATIVE = 2'b11
	} branch_cond_t;

endpackage

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import datapath_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	input  wire         r_enable,
	input  reg_onehot_t reg_select,
	input  word_t       bus_data,
	output word_t       reg_out
);

	word_t regs [REG_COUNT];

	always_ff @(posedge clk) begin
		for (int i = 0; i < REG_COUNT; i++) begin
			if (rst)
				regs[i] <= '0;
			else if (r_enable && reg_select[i])
				regs[i] <= bus_data;
		end
	end

	// And-or read, an empty select reads zero
	always_comb begin
		reg_out = '0;
		for (int i = 0; i < REG_COUNT; i++)
			reg_out = reg_out | (regs[i] & {$bits(word_t){reg_select[i]}});
	end

endmodule

`default_nettype wire

/* verilog/select_encode.sv */
`timescale 1ns/1ps
`default_nettype none

module select_encode import datapath_pkg::*; (
	input  word_t       ir_data,
	input  wire         gra,
	input  wire         grb,
	input  wire         grc,
	input  wire         ba_out,
	output reg_onehot_t reg_select,
	output word_t       c_sign_extended
);

	reg_idx_t reg_idx;
	logic     field_valid;

	// Pick one register field out of IR
	always_comb begin
		field_valid = gra | grb | grc;
		if (gra)
			reg_idx = ir_data[IR_RA_MSB -: $bits(reg_idx_t)];
		else if (grb)
			reg_idx = ir_data[IR_RB_MSB -: $bits(reg_idx_t)];
		else if (grc)
			reg_idx = ir_data[IR_RC_MSB -: $bits(reg_idx_t)];
		else
			reg_idx = '0;
	end

	always_comb begin
		reg_select = '0;
		if (field_valid)
			reg_select = reg_onehot_t'(1) << reg_idx;
		// Base-address mode: R0 reads as zero
		if (ba_out && reg_idx == '0)
			reg_select = '0;
	end

	assign c_sign_extended = {{($bits(word_t) - IR_C_WIDTH){ir_data[IR_C_WIDTH-1]}},
		ir_data[IR_C_WIDTH-1:0]};

endmodule

`default_nettype wire

/* verilog/bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_mux import datapath_pkg::*; (
	input  wire   pc_select,
	input  wire   z_lo_select,
	input  wire   z_hi_select,
	input  wire   mdr_select,
	input  wire   c_select,
	input  wire   r_select,
	input  word_t reg_out,
	input  word_t pc_data,
	input  word_t z_lo_data,
	input  word_t z_hi_data,
	input  word_t mdr_data,
	input  word_t c_sign_extended,
	output word_t bus_data
);

	logic [2:0] src;

	// Priority encoder, constant wins
	always_comb begin
		if (c_select)         src = 3'd1;
		else if (pc_select)   src = 3'd2;
		else if (mdr_select)  src = 3'd3;
		else if (z_lo_select) src = 3'd4;
		else if (z_hi_select) src = 3'd5;
		else if (r_select)    src = 3'd6;
		else                  src = 3'd0;
	end

	always_comb begin
		case (src)
			3'd1:    bus_data = c_sign_extended;
			3'd2:    bus_data = pc_data;
			3'd3:    bus_data = mdr_data;
			3'd4:    bus_data = z_lo_data;
			3'd5:    bus_data = z_hi_data;
			3'd6:    bus_data = reg_out;
			default: bus_data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import datapath_pkg::*; (
	input  word_t   y_data,
	input  word_t   bus_data,
	input  alu_op_t alu_op,
	output dword_t  result
);

	word_t             a;
	word_t             b;
	word_t             narrow;
	logic signed [63:0] product;
	logic [4:0]        shamt;

	assign a     = y_data;
	assign b     = bus_data;
	assign shamt = b[4:0];

	// Full signed product
	assign product = $signed(a) * $signed(b);

	always_comb begin
		narrow = '0;
		case (alu_op)
			ALU_ADD: narrow = a + b;
			ALU_SUB: narrow = a - b;
			ALU_AND: narrow = a & b;
			ALU_OR:  narrow = a | b;
			ALU_SHR: narrow = a >> shamt;
			ALU_SHL: narrow = a << shamt;
			// Unary ops work on the bus operand
			ALU_NEG: narrow = -b;
			ALU_NOT: narrow = ~b;
			default: narrow = '0;
		endcase
	end

	always_comb begin
		if (alu_op == ALU_MUL)
			result = dword_t'(product);
		else
			result = {32'd0, narrow};
	end

endmodule

`default_nettype wire

/* verilog/special_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module special_registers import datapath_pkg::*; (
	input  wire    clk,
	input  wire    rst,
	input  wire    pc_enable,
	input  wire    pc_increment_enable,
	input  wire    ir_enable,
	input  wire    y_enable,
	input  wire    z_enable,
	input  word_t  bus_data,
	input  dword_t alu_result,
	output word_t  pc_data,
	output word_t  ir_data,
	output word_t  y_data,
	output word_t  z_hi_data,
	output word_t  z_lo_data
);

	dword_t z_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_data <= '0;
			ir_data <= '0;
			y_data  <= '0;
			z_data  <= '0;
		end else begin
			// A bus load overrides the increment
			if (pc_enable)
				pc_data <= bus_data;
			else if (pc_increment_enable)
				pc_data <= pc_data + word_t'(1);
			if (ir_enable)
				ir_data <= bus_data;
			if (y_enable)
				y_data <= bus_data;
			if (z_enable)
				z_data <= alu_result;
		end
	end

	assign z_hi_data = z_data[63:32];
	assign z_lo_data = z_data[31:0];

endmodule

`default_nettype wire

/* verilog/con_ff.sv */
`timescale 1ns/1ps
`default_nettype none

module con_ff import datapath_pkg::*; (
	input  wire   clk,
	input  wire   rst,
	input  wire   con_enable,
	input  word_t ir_data,
	input  word_t bus_data,
	output logic  con_output
);

	branch_cond_t c2;
	logic         is_zero;
	logic         cond_met;

	assign c2      = branch_cond_t'(ir_data[IR_C2_LSB +: 2]);
	assign is_zero = (bus_data == '0);

	always_comb begin
		case (c2)
			BR_ZERO:     cond_met = is_zero;
			BR_NONZERO:  cond_met = !is_zero;
			BR_POSITIVE: cond_met = !bus_data[31] && !is_zero;
			default:     cond_met = bus_data[31];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			con_output <= 1'b0;
		else if (con_enable)
			con_output <= cond_met;
	end

endmodule

`default_nettype wire

/* verilog/memory_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_unit import datapath_pkg::*; #(
	parameter int mem_depth = 512
) (
	input  wire       clk,
	input  wire       rst,
	input  wire       mar_enable,
	input  wire       mdr_enable,
	input  wire       read,
	input  wire       write,
	input  word_t     bus_data,
	input  wire       load_we,
	input  mem_addr_t load_addr,
	input  word_t     load_data,
	output word_t     mar_data,
	output word_t     mdr_data
);

	word_t     mem [mem_depth];
	mem_addr_t mem_addr;
	word_t     mdr_in;

	assign mem_addr = mar_data[$bits(mem_addr_t)-1:0];

	// Asynchronous read feeds the MDR input mux
	assign mdr_in = read ? mem[mem_addr] : bus_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			mar_data <= '0;
			mdr_data <= '0;
		end else begin
			if (mar_enable)
				mar_data <= bus_data;
			if (mdr_enable)
				mdr_data <= mdr_in;
		end
	end

	// CPU store takes precedence over the program-load port
	always_ff @(posedge clk) begin
		if (write)
			mem[mem_addr] <= mdr_data;
		else if (load_we)
			mem[load_addr] <= load_data;
	end

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath import datapath_pkg::*; #(
	parameter int mem_depth = 512
) (
	input  wire       clk,
	input  wire       rst,
	input  wire       pc_enable,
	input  wire       pc_increment_enable,
	input  wire       ir_enable,
	input  wire       y_enable,
	input  wire       z_enable,
	input  wire       mar_enable,
	input  wire       mdr_enable,
	input  wire       r_enable,
	input  wire       con_enable,
	input  wire       read,
	input  wire       write,
	input  wire       gra,
	input  wire       grb,
	input  wire       grc,
	input  wire       ba_out,
	input  wire       pc_select,
	input  wire       z_lo_select,
	input  wire       z_hi_select,
	input  wire       mdr_select,
	input  wire       c_select,
	input  wire       r_select,
	input  alu_op_t   alu_op,
	input  wire       load_we,
	input  mem_addr_t load_addr,
	input  word_t     load_data,
	output word_t     bus_data,
	output word_t     pc_data,
	output word_t     ir_data,
	output word_t     y_data,
	output word_t     z_hi_data,
	output word_t     z_lo_data,
	output word_t     mar_data,
	output word_t     mdr_data,
	output logic      con_output
);

	reg_onehot_t reg_select;
	word_t       reg_out;
	word_t       c_sign_extended;
	dword_t      alu_result;

	select_encode i_select_encode (
		.ir_data(ir_data), .gra(gra), .grb(grb), .grc(grc), .ba_out(ba_out),
		.reg_select(reg_select), .c_sign_extended(c_sign_extended)
	);

	register_file i_register_file (
		.clk(clk), .rst(rst), .r_enable(r_enable), .reg_select(reg_select),
		.bus_data(bus_data), .reg_out(reg_out)
	);

	// The single shared bus
	bus_mux i_bus_mux (
		.pc_select(pc_select), .z_lo_select(z_lo_select), .z_hi_select(z_hi_select),
		.mdr_select(mdr_select), .c_select(c_select), .r_select(r_select),
		.reg_out(reg_out), .pc_data(pc_data), .z_lo_data(z_lo_data),
		.z_hi_data(z_hi_data), .mdr_data(mdr_data), .c_sign_extended(c_sign_extended),
		.bus_data(bus_data)
	);

	alu i_alu (.y_data(y_data), .bus_data(bus_data), .alu_op(alu_op), .result(alu_result));

	special_registers i_special_registers (
		.clk(clk), .rst(rst), .pc_enable(pc_enable),
		.pc_increment_enable(pc_increment_enable), .ir_enable(ir_enable),
		.y_enable(y_enable), .z_enable(z_enable), .bus_data(bus_data),
		.alu_result(alu_result), .pc_data(pc_data), .ir_data(ir_data),
		.y_data(y_data), .z_hi_data(z_hi_data), .z_lo_data(z_lo_data)
	);

	con_ff i_con_ff (
		.clk(clk), .rst(rst), .con_enable(con_enable), .ir_data(ir_data),
		.bus_data(bus_data), .con_output(con_output)
	);

	memory_unit #(.mem_depth(mem_depth)) i_memory_unit (
		.clk(clk), .rst(rst), .mar_enable(mar_enable), .mdr_enable(mdr_enable),
		.read(read), .write(write), .bus_data(bus_data), .load_we(load_we),
		.load_addr(load_addr), .load_data(load_data),
		.mar_data(mar_data), .mdr_data(mdr_data)
	);

endmodule

`default_nettype wire

/* sim/datapath_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath_tb import datapath_pkg::*; ();

	localparam int MEM_DEPTH = 512;
	localparam int N_STEPS   = 40;
	localparam int MAX_INSTR = 2 * N_STEPS;
	localparam int K_LDI = 0;
	localparam int K_ALU = 1;
	localparam int K_LD  = 2;
	localparam int K_ST  = 3;
	localparam int K_BR  = 4;

	logic clk, rst;
	logic pc_enable, pc_increment_enable, ir_enable, y_enable, z_enable;
	logic mar_enable, mdr_enable, r_enable, con_enable, read, write;
	logic gra, grb, grc, ba_out;
	logic pc_select, z_lo_select, z_hi_select, mdr_select, c_select, r_select;
	alu_op_t   alu_op;
	logic      load_we;
	mem_addr_t load_addr;
	word_t     load_data;
	word_t     bus_data, pc_data, ir_data, y_data, z_hi_data, z_lo_data, mar_data, mdr_data;
	logic      con_output;

	// Reference state and the generated instruction stream
	word_t       image [MEM_DEPTH];
	word_t       model_mem [MEM_DEPTH];
	word_t       model_reg [16];
	word_t       model_pc;
	int          n_instr;
	int          kind [MAX_INSTR];
	word_t       word_q [MAX_INSTR];
	alu_op_t     op_q [MAX_INSTR];
	logic [63:0] exp1 [MAX_INSTR];
	logic [63:0] exp2 [MAX_INSTR];
	alu_op_t     op_list [9] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SHR, ALU_SHL,
		ALU_NEG, ALU_NOT, ALU_MUL};
	integer      seed = 32'hfc361cf4;
	int          limit = 0;
	int          cycle_count = 0;

	datapath #(.mem_depth(MEM_DEPTH)) i_datapath (
		.clk(clk), .rst(rst), .pc_enable(pc_enable), .pc_increment_enable(pc_increment_enable),
		.ir_enable(ir_enable), .y_enable(y_enable), .z_enable(z_enable),
		.mar_enable(mar_enable), .mdr_enable(mdr_enable), .r_enable(r_enable),
		.con_enable(con_enable), .read(read), .write(write), .gra(gra), .grb(grb),
		.grc(grc), .ba_out(ba_out), .pc_select(pc_select), .z_lo_select(z_lo_select),
		.z_hi_select(z_hi_select), .mdr_select(mdr_select), .c_select(c_select),
		.r_select(r_select), .alu_op(alu_op), .load_we(load_we), .load_addr(load_addr),
		.load_data(load_data), .bus_data(bus_data), .pc_data(pc_data), .ir_data(ir_data),
		.y_data(y_data), .z_hi_data(z_hi_data), .z_lo_data(z_lo_data),
		.mar_data(mar_data), .mdr_data(mdr_data), .con_output(con_output)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > limit) begin
			$display("timeout: run still going after %0d cycles", limit);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic word_t sext(input logic [18:0] c);
		return {{13{c[18]}}, c};
	endfunction

	// Opcode in the top five bits is read by the testbench alone
	function automatic word_t encode(input int k, input reg_idx_t ra, input reg_idx_t rb,
		input logic [18:0] c);
		return {k[4:0], ra, rb, c};
	endfunction

	function automatic word_t base_val(input reg_idx_t rb);
		return (rb == 0) ? 32'd0 : model_reg[rb];
	endfunction

	function automatic logic [63:0] alu_model(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			ALU_ADD: return {32'd0, a + b};
			ALU_SUB: return {32'd0, a - b};
			ALU_AND: return {32'd0, a & b};
			ALU_OR:  return {32'd0, a | b};
			ALU_SHR: return {32'd0, a >> b[4:0]};
			ALU_SHL: return {32'd0, a << b[4:0]};
			ALU_NEG: return {32'd0, 32'd0 - b};
			ALU_NOT: return {32'd0, ~b};
			ALU_MUL: return longint'($signed(a)) * longint'($signed(b));
			default: return 64'd0;
		endcase
	endfunction

	function automatic logic cond_model(input logic [1:0] c2, input word_t v);
		case (branch_cond_t'(c2))
			BR_ZERO:     return v == 0;
			BR_NONZERO:  return v != 0;
			BR_POSITIVE: return !v[31] && v != 0;
			default:     return v[31];
		endcase
	endfunction

	function automatic int phase_count(input int k);
		case (k)
			K_LD:    return 9;
			K_ST:    return 8;
			default: return 7;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic add_instr(input int k, input word_t w, input alu_op_t op);
		image[model_pc[8:0]] = w;
		model_mem[model_pc[8:0]] = w;
		kind[n_instr] = k;
		word_q[n_instr] = w;
		op_q[n_instr] = op;
		limit += phase_count(k);
		n_instr++;
		model_pc++;
	endtask

	task automatic gen_load(input reg_idx_t ra, input reg_idx_t rb, input logic [18:0] c);
		word_t addr;
		addr = base_val(rb) + sext(c);
		// Loads stay in the upper half, away from program words placed later
		if (!addr[8]) begin
			c = c ^ 19'h100;
			addr = base_val(rb) + sext(c);
		end
		add_instr(K_LD, encode(K_LD, ra, rb, c), ALU_ADD);
		model_reg[ra] = model_mem[addr[8:0]];
		exp1[n_instr-1] = model_reg[ra];
	endtask

	// Program grows upward from 0 while loads and stores use the upper half
	task automatic build_program();
		int          k;
		reg_idx_t    ra, rb, rc;
		logic [18:0] c;
		logic [63:0] z;
		logic        taken;
		for (int a = 0; a < MEM_DEPTH; a++) begin
			image[a] = $random(seed);
			model_mem[a] = image[a];
		end
		for (int r = 0; r < 16; r++)
			model_reg[r] = 0;
		model_pc = 0;
		n_instr = 0;
		limit = MEM_DEPTH + 60;
		for (int s = 0; s < N_STEPS; s++) begin
			k = $unsigned($random(seed)) % 5;
			ra = reg_idx_t'($random(seed));
			rb = reg_idx_t'($random(seed));
			rc = reg_idx_t'($random(seed));
			c = 19'($random(seed));
			case (k)
				K_LDI: begin
					if ($random(seed) & 1)
						rb = 0;
					add_instr(K_LDI, encode(K_LDI, ra, rb, c), ALU_ADD);
					model_reg[ra] = base_val(rb) + sext(c);
					exp1[n_instr-1] = model_reg[ra];
				end
				K_ALU: begin
					add_instr(K_ALU, encode(K_ALU, ra, rb, {rc, c[14:0]}),
						op_list[$unsigned($random(seed)) % 9]);
					z = alu_model(op_q[n_instr-1], model_reg[rb], model_reg[rc]);
					exp2[n_instr-1] = model_reg[rb];
					model_reg[ra] = z[31:0];
					exp1[n_instr-1] = z;
				end
				K_LD:
					gen_load(ra, rb, c);
				K_ST: begin
					c = 19'd256 + c[7:0];
					add_instr(K_ST, encode(K_ST, ra, 0, c), ALU_ADD);
					exp1[n_instr-1] = model_reg[ra];
					model_mem[c[8:0]] = model_reg[ra];
					gen_load(rc, 0, c);
				end
				default: begin
					// C2 rides in the low bits of the rb field
					c = c & 19'h3;
					add_instr(K_BR, encode(K_BR, ra, {2'b00, rb[1:0]}, c), ALU_ADD);
					taken = cond_model(rb[1:0], model_reg[ra]);
					if (taken)
						model_pc = model_pc + sext(c);
					exp1[n_instr-1] = taken;
					exp2[n_instr-1] = model_pc;
				end
			endcase
		end
	endtask

	task automatic idle_controls();
		{pc_enable, pc_increment_enable, ir_enable, y_enable, z_enable} = '0;
		{mar_enable, mdr_enable, r_enable, con_enable, read, write} = '0;
		{gra, grb, grc, ba_out} = '0;
		{pc_select, z_lo_select, z_hi_select, mdr_select, c_select, r_select} = '0;
		alu_op = ALU_ADD;
	endtask

	// One control phase ending at the falling edge
	task automatic cycle();
		@(negedge clk);
		idle_controls();
	endtask

	task automatic fetch();
		pc_select = 1;
		mar_enable = 1;
		cycle();
		read = 1;
		mdr_enable = 1;
		pc_increment_enable = 1;
		cycle();
		mdr_select = 1;
		ir_enable = 1;
		cycle();
	endtask

	// Y gets rb with R0 as zero and Z gets Y plus C
	task automatic base_plus_c();
		grb = 1;
		ba_out = 1;
		r_select = 1;
		y_enable = 1;
		cycle();
		c_select = 1;
		alu_op = ALU_ADD;
		z_enable = 1;
		cycle();
	endtask

	task automatic read_back(input string name, input logic [63:0] expected);
		gra = 1;
		r_select = 1;
		#1;
		check_value(name, expected, {32'd0, bus_data});
		cycle();
	endtask

	task automatic run_ldi(input int i);
		base_plus_c();
		z_lo_select = 1;
		gra = 1;
		r_enable = 1;
		cycle();
		read_back("load immediate", exp1[i]);
	endtask

	task automatic run_alu(input int i);
		grb = 1;
		r_select = 1;
		y_enable = 1;
		cycle();
		check_value("alu y", exp2[i], y_data);
		grc = 1;
		r_select = 1;
		alu_op = op_q[i];
		z_enable = 1;
		cycle();
		check_value("alu z_lo", exp1[i][31:0], z_lo_data);
		check_value("alu z_hi", exp1[i][63:32], z_hi_data);
		z_lo_select = 1;
		gra = 1;
		r_enable = 1;
		cycle();
		read_back("alu destination", exp1[i][31:0]);
	endtask

	task automatic run_ld(input int i);
		base_plus_c();
		z_lo_select = 1;
		mar_enable = 1;
		cycle();
		read = 1;
		mdr_enable = 1;
		cycle();
		check_value("load mdr", exp1[i], mdr_data);
		mdr_select = 1;
		gra = 1;
		r_enable = 1;
		cycle();
		read_back("load destination", exp1[i]);
	endtask

	task automatic run_st(input int i);
		base_plus_c();
		z_lo_select = 1;
		mar_enable = 1;
		cycle();
		gra = 1;
		r_select = 1;
		mdr_enable = 1;
		cycle();
		check_value("store mdr", exp1[i], mdr_data);
		write = 1;
		cycle();
	endtask

	task automatic run_branch(input int i);
		gra = 1;
		r_select = 1;
		con_enable = 1;
		cycle();
		check_value("branch condition", exp1[i], con_output);
		pc_select = 1;
		y_enable = 1;
		cycle();
		c_select = 1;
		alu_op = ALU_ADD;
		z_enable = 1;
		cycle();
		z_lo_select = 1;
		pc_enable = con_output;
		cycle();
		check_value("branch pc", exp2[i], pc_data);
	endtask

	initial begin
		clk = 0;
		rst = 0;
		idle_controls();
		load_we = 0;
		load_addr = '0;
		load_data = '0;
		build_program();
		for (int a = 0; a < MEM_DEPTH; a++) begin
			@(negedge clk);
			load_we = 1;
			load_addr = mem_addr_t'(a);
			load_data = image[a];
		end
		@(negedge clk);
		load_we = 0;
		rst = 1;
		repeat (3) @(negedge clk);
		rst = 0;
		check_value("reset pc", 0, pc_data);
		check_value("reset ir", 0, ir_data);
		check_value("reset z_lo", 0, z_lo_data);
		check_value("reset mar", 0, mar_data);
		check_value("reset mdr", 0, mdr_data);
		check_value("reset con", 0, con_output);
		for (int i = 0; i < n_instr; i++) begin
			fetch();
			check_value("fetch ir", word_q[i], ir_data);
			case (kind[i])
				K_LDI:   run_ldi(i);
				K_ALU:   run_alu(i);
				K_LD:    run_ld(i);
				K_ST:    run_st(i);
				default: run_branch(i);
			endcase
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* datapath.f */
verilog/datapath_pkg.sv
verilog/register_file.sv
verilog/select_encode.sv
verilog/bus_mux.sv
verilog/alu.sv
verilog/special_registers.sv
verilog/con_ff.sv
verilog/memory_unit.sv
verilog/datapath.sv
sim/datapath_tb.sv
